// ==== pipe_core.f ====
+incdir+verilog
verilog/core_pkg.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/pipe_regs.sv
verilog/pipe_control.sv
verilog/data_mem.sv
verilog/pipe_core.sv
testbench/pipe_core_asserts.sv
testbench/pipe_core_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vpipe_core_tb
SOURCES := $(wildcard verilog/*.sv verilog/*.svh testbench/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): pipe_core.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
		-f pipe_core.f --top-module pipe_core_tb -o Vpipe_core_tb

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	@cat sim.log
	@! grep -q "Finished with errors" sim.log
	@grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/pipe_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module pipe_core_tb;
	import core_pkg::*;

	logic      clock;
	logic      rst_n;
	pc_t       imem_addr;
	instr_t    imem_data;
	logic      wb_valid;
	reg_addr_t wb_addr;
	word_t     wb_data;

	instr_t    prog [2**`CORE_PC_W]; // unused addresses stay NOP
	int        prog_len;
	word_t     arch [`CORE_NREGS];
	word_t     dmem_model [`CORE_DMEM_WORDS];
	reg_addr_t exp_addr [$];
	word_t     exp_data [$];
	int        seed;
	int        timeout_limit;
	int        cycles = 0;

	pipe_core UUT (
		.clock(clock),
		.rst_n(rst_n),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_data(wb_data)
	);

	assign imem_data = prog[imem_addr]; // combinational instruction port

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic word_t sign_extend(input imm_t imm);
		return word_t'($signed(imm));
	endfunction

	function automatic instr_t encode_r(input alu_fn_e fn, input reg_addr_t rd,
		input reg_addr_t ra, input reg_addr_t rt);
		return {OP_ALU, rd, ra, rt, 6'd0, fn};
	endfunction

	function automatic instr_t encode_i(input opcode_e op, input reg_addr_t rd,
		input reg_addr_t ra, input imm_t imm);
		return {op, rd, ra, 2'b00, imm};
	endfunction

	task automatic place_instr(input instr_t instr);
		prog[prog_len] = instr;
		prog_len++;
	endtask

	// register zero is never written, so it never reaches the writeback port
	task automatic expect_write(input reg_addr_t rd, input word_t value);
		if (rd != '0) begin
			arch[rd] = value;
			exp_addr.push_back(rd);
			exp_data.push_back(value);
		end
	endtask

	task automatic addi_instr(input reg_addr_t rd, input reg_addr_t ra, input imm_t imm);
		place_instr(encode_i(OP_ADDI, rd, ra, imm));
		expect_write(rd, arch[ra] + sign_extend(imm));
	endtask

	task automatic alu_instr(input alu_fn_e fn, input reg_addr_t rd,
		input reg_addr_t ra, input reg_addr_t rt);
		word_t a;
		word_t b;
		word_t v;
		a = arch[ra];
		b = arch[rt];
		case (fn)
			FN_ADD: v = a + b;
			FN_SUB: v = a - b;
			FN_AND: v = a & b;
			FN_OR: v = a | b;
			FN_XOR: v = a ^ b;
			FN_SLT: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: v = '0;
		endcase
		place_instr(encode_r(fn, rd, ra, rt));
		expect_write(rd, v);
	endtask

	task automatic store_instr(input reg_addr_t src, input reg_addr_t base, input imm_t off);
		word_t addr;
		addr = arch[base] + sign_extend(off);
		place_instr(encode_i(OP_SW, src, base, off));
		dmem_model[addr % `CORE_DMEM_WORDS] = arch[src];
	endtask

	task automatic load_instr(input reg_addr_t rd, input reg_addr_t base, input imm_t off);
		word_t addr;
		addr = arch[base] + sign_extend(off);
		place_instr(encode_i(OP_LW, rd, base, off));
		expect_write(rd, dmem_model[addr % `CORE_DMEM_WORDS]);
	endtask

	task automatic branch_instr(input reg_addr_t ra, input reg_addr_t rb);
		logic taken;
		imm_t target;
		taken = (arch[ra] == arch[rb]);
		target = imm_t'(prog_len + 4);
		place_instr(encode_i(OP_BEQ, rb, ra, target));
		// three ADDIs in the branch shadow only count when it falls through
		for (int k = 0; k < 3; k++) begin
			place_instr(encode_i(OP_ADDI, reg_addr_t'(20 + k), 5'd0, imm_t'(100 + k)));
			if (!taken)
				expect_write(reg_addr_t'(20 + k), word_t'(100 + k));
		end
	endtask

	task automatic build_program();
		seed = 32'h0c3b_68e5;
		prog_len = 0;
		for (int i = 0; i < 2**`CORE_PC_W; i++)
			prog[i] = '0;
		for (int i = 0; i < `CORE_NREGS; i++)
			arch[i] = '0;
		for (int i = 0; i < `CORE_DMEM_WORDS; i++)
			dmem_model[i] = '0;
		addi_instr(1, 0, imm_t'($random(seed)) & 14'h1fff); // r1 kept positive
		addi_instr(2, 0, imm_t'($random(seed)) | 14'h2000); // r2 kept negative
		addi_instr(3, 0, imm_t'($random(seed)));
		addi_instr(4, 0, imm_t'($random(seed)));
		alu_instr(FN_ADD, 5, 1, 2);
		alu_instr(FN_SUB, 6, 1, 2);
		alu_instr(FN_AND, 7, 3, 4);
		alu_instr(FN_OR, 8, 3, 4);
		alu_instr(FN_XOR, 9, 1, 3);
		alu_instr(FN_SLT, 10, 2, 1);
		alu_instr(FN_SLT, 11, 1, 2);
		addi_instr(12, 5, imm_t'($random(seed))); // dependent chain from here
		alu_instr(FN_ADD, 13, 12, 12);
		alu_instr(FN_SUB, 14, 13, 1);
		alu_instr(FN_XOR, 15, 14, 13);
		store_instr(15, 0, 14'd5);
		load_instr(16, 0, 14'd5);
		store_instr(6, 1, 14'd3);
		load_instr(17, 1, 14'd3);
		alu_instr(FN_ADD, 18, 16, 17);
		branch_instr(1, 1); // always taken
		addi_instr(24, 0, imm_t'($random(seed)));
		branch_instr(1, 2); // signs differ, so never taken
		addi_instr(0, 1, imm_t'($random(seed)));
		alu_instr(FN_OR, 19, 0, 0);
		alu_instr(FN_ADD, 25, 0, 3);
	endtask

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("FAILED %s expected %h got %h", name, expected, actual);
			$display("Finished with errors");
			$fatal(1, "value mismatch");
		end
	endtask

	always @(posedge clock) begin
		if (rst_n) begin
			cycles <= cycles + 1;
			if (cycles > timeout_limit) begin
				$display("run timed out before all writebacks");
				$display("Finished with errors");
				$fatal(1, "timeout");
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		build_program();
		timeout_limit = 6 * prog_len + 40;
		repeat (8) @(posedge clock);
		rst_n <= 1'b1;
		for (int row = 0; row < exp_addr.size(); row++) begin
			do begin
				@(negedge clock);
			end while (!wb_valid);
			check_value("wb_addr", word_t'(exp_addr[row]), word_t'(wb_addr));
			check_value("wb_data", exp_data[row], wb_data);
		end
		// the program runs into NOPs, so nothing else may write back
		repeat (12) begin
			@(negedge clock);
			check_value("wb_valid", 32'd0, word_t'(wb_valid));
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/pipe_core_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_core_asserts (
	input logic                clock,
	input logic                rst_n,
	input core_pkg::pc_t       imem_addr,
	input logic                hold_if,
	input logic                wb_valid,
	input core_pkg::reg_addr_t wb_addr
);

	wb_addr_nonzero: assert property (@(posedge clock) disable iff (!rst_n)
		wb_valid |-> wb_addr != '0)
		else $error("writeback reported for register zero");

	stall_holds_pc: assert property (@(posedge clock) disable iff (!rst_n)
		hold_if |=> $stable(imem_addr))
		else $error("instruction address moved during a stall");

	// pc was cleared by the last reset edge
	pc_zero_after_reset: assert property (@(posedge clock)
		$rose(rst_n) |-> imem_addr == '0)
		else $error("instruction address not zero after reset");

endmodule

bind pipe_core pipe_core_asserts u_asserts (
	.clock(clock),
	.rst_n(rst_n),
	.imem_addr(imem_addr),
	.hold_if(hold_if),
	.wb_valid(wb_valid),
	.wb_addr(wb_addr)
);

`default_nettype wire

// ==== verilog/pipe_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_core (
	input  logic                clock,
	input  logic                rst_n,
	output core_pkg::pc_t       imem_addr,
	input  core_pkg::instr_t    imem_data,
	output logic                wb_valid,
	output core_pkg::reg_addr_t wb_addr,
	output core_pkg::word_t     wb_data
);
	import core_pkg::*;

	instr_t    id_instr;
	ctrl_t     dec_ctrl;
	reg_addr_t ra_addr;
	reg_addr_t rt_addr;
	logic      uses_ra;
	logic      uses_rt;
	imm_t      dec_imm;
	word_t     dec_imm_extend;
	word_t     ra_data;
	word_t     rt_data;
	id_ex_t    id_in;
	id_ex_t    ex_stage;
	word_t     alu_result;
	logic      branch_taken;
	ex_mem_t   ex_in;
	ex_mem_t   mem_stage;
	word_t     dm_rdata;
	mem_wb_t   wb_in;
	mem_wb_t   wb_stage;
	logic      hold_if;
	logic      flush_if;
	logic      flush_id;
	logic      flush_ex;

	pipe_control u_control (
		.clock(clock),
		.rst_n(rst_n),
		.uses_ra(uses_ra),
		.uses_rt(uses_rt),
		.ra_addr(ra_addr),
		.rt_addr(rt_addr),
		.ex_stage(ex_stage),
		.mem_stage(mem_stage),
		.pc(imem_addr),
		.hold_if(hold_if),
		.flush_if(flush_if),
		.flush_id(flush_id),
		.flush_ex(flush_ex)
	);

	pipe_regs u_regs (
		.clock(clock),
		.rst_n(rst_n),
		.if_instr(imem_data),
		.id_instr(id_instr),
		.id_in(id_in),
		.ex_stage(ex_stage),
		.ex_in(ex_in),
		.mem_stage(mem_stage),
		.wb_in(wb_in),
		.wb_stage(wb_stage),
		.hold_if(hold_if),
		.flush_if(flush_if),
		.flush_id(flush_id),
		.flush_ex(flush_ex)
	);

	instr_decoder u_decoder (
		.instr(id_instr),
		.ctrl(dec_ctrl),
		.ra_addr(ra_addr),
		.rt_addr(rt_addr),
		.uses_ra(uses_ra),
		.uses_rt(uses_rt),
		.imm(dec_imm),
		.imm_extend(dec_imm_extend)
	);

	reg_file u_reg_file (
		.clock(clock),
		.rst_n(rst_n),
		.ra_addr(ra_addr),
		.rt_addr(rt_addr),
		.ra_data(ra_data),
		.rt_data(rt_data),
		.we(wb_stage.do_reg_write),
		.wa(wb_stage.write_reg_addr),
		.wd(wb_stage.write_reg_data)
	);

	assign id_in = '{
		ctrl: dec_ctrl,
		ra_data: ra_data,
		rt_data: rt_data,
		imm_extend: dec_imm_extend,
		imm: dec_imm
	};

	alu u_alu (
		.stage(ex_stage),
		.result(alu_result),
		.branch_taken(branch_taken)
	);

	assign ex_in = '{
		ctrl: ex_stage.ctrl,
		alu_result: alu_result,
		rt_data: ex_stage.rt_data,
		branch_taken: branch_taken
	};

	data_mem u_data_mem (
		.clock(clock),
		.rst_n(rst_n),
		.addr(mem_stage.alu_result),
		.wdata(mem_stage.rt_data),
		.we(mem_stage.ctrl.do_dm_write),
		.re(mem_stage.ctrl.do_dm_read),
		.rdata(dm_rdata)
	);

	assign wb_in = '{
		do_reg_write: mem_stage.ctrl.do_reg_write,
		write_reg_addr: mem_stage.ctrl.write_reg_addr,
		write_reg_data: (mem_stage.ctrl.wb_sel == WB_MEM) ? dm_rdata : mem_stage.alu_result
	};

	assign wb_valid = wb_stage.do_reg_write;
	assign wb_addr = wb_stage.write_reg_addr;
	assign wb_data = wb_stage.write_reg_data;

endmodule

`default_nettype wire

// ==== verilog/data_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module data_mem (
	input  logic            clock,
	input  logic            rst_n,
	input  core_pkg::word_t addr,
	input  core_pkg::word_t wdata,
	input  logic            we,
	input  logic            re,
	output core_pkg::word_t rdata
);
	import core_pkg::*;

	localparam int AW = $clog2(`CORE_DMEM_WORDS);

	word_t          mem [`CORE_DMEM_WORDS];
	logic  [AW-1:0] idx;

	assign idx = addr[AW-1:0]; // word address, upper bits wrap

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < `CORE_DMEM_WORDS; i++)
				mem[i] <= '0;
		end else if (we) begin
			mem[idx] <= wdata;
		end
	end

	assign rdata = re ? mem[idx] : '0;

endmodule

`default_nettype wire

// ==== verilog/pipe_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_control (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                uses_ra,
	input  logic                uses_rt,
	input  core_pkg::reg_addr_t ra_addr,
	input  core_pkg::reg_addr_t rt_addr,
	input  core_pkg::id_ex_t    ex_stage,
	input  core_pkg::ex_mem_t   mem_stage,
	output core_pkg::pc_t       pc,
	output logic                hold_if,
	output logic                flush_if,
	output logic                flush_id,
	output logic                flush_ex
);
	import core_pkg::*;

	logic stall;
	logic redirect;
	pc_t  target;

	function automatic logic pending(input logic used, input reg_addr_t src, input ctrl_t c);
		pending = used && (src != '0) && c.do_reg_write && (c.write_reg_addr == src);
	endfunction

	// the MEM/WB write is covered by the register file bypass
	assign stall = pending(uses_ra, ra_addr, ex_stage.ctrl) ||
		pending(uses_ra, ra_addr, mem_stage.ctrl) ||
		pending(uses_rt, rt_addr, ex_stage.ctrl) ||
		pending(uses_rt, rt_addr, mem_stage.ctrl);

	assign redirect = mem_stage.branch_taken;
	assign target = pc_t'(mem_stage.alu_result);

	assign hold_if = stall && !redirect; // a taken branch wins over the stall
	assign flush_if = redirect;
	assign flush_id = redirect || stall;
	assign flush_ex = redirect;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= target;
		end else if (!stall) begin
			pc <= pc + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/pipe_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_regs (
	input  logic              clock,
	input  logic              rst_n,
	input  core_pkg::instr_t  if_instr,
	output core_pkg::instr_t  id_instr,
	input  core_pkg::id_ex_t  id_in,
	output core_pkg::id_ex_t  ex_stage,
	input  core_pkg::ex_mem_t ex_in,
	output core_pkg::ex_mem_t mem_stage,
	input  core_pkg::mem_wb_t wb_in,
	output core_pkg::mem_wb_t wb_stage,
	input  logic              hold_if,
	input  logic              flush_if,
	input  logic              flush_id,
	input  logic              flush_ex
);

	// IF/ID keeps the stalled instruction until decode can issue it
	always_ff @(posedge clock) begin
		if (!rst_n || flush_if) begin
			id_instr <= '0;
		end else if (!hold_if) begin
			id_instr <= if_instr;
		end
	end

	// ID/EX is also flushed for a stall, which turns it into a bubble
	always_ff @(posedge clock) begin
		if (!rst_n || flush_id) begin
			ex_stage <= '0;
		end else begin
			ex_stage <= id_in;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n || flush_ex) begin
			mem_stage <= '0;
		end else begin
			mem_stage <= ex_in;
		end
	end

	// MEM/WB only holds instructions older than any branch in flight
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wb_stage <= '0;
		end else begin
			wb_stage <= wb_in;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
	input  core_pkg::id_ex_t stage,
	output core_pkg::word_t  result,
	output logic             branch_taken
);
	import core_pkg::*;

	word_t a;
	word_t b;
	word_t fn_result;

	assign a = stage.ra_data;
	assign b = stage.ctrl.alu_use_imm ? stage.imm_extend : stage.rt_data;

	always_comb begin
		case (stage.ctrl.alu_fn)
			FN_ADD: fn_result = a + b;
			FN_SUB: fn_result = a - b;
			FN_AND: fn_result = a & b;
			FN_OR: fn_result = a | b;
			FN_XOR: fn_result = a ^ b;
			FN_SLT: fn_result = word_t'($signed(a) < $signed(b));
			default: fn_result = '0;
		endcase
	end

	// a branch carries its absolute target down the pipe in the result field
	assign result = stage.ctrl.is_branch ? word_t'(stage.imm) : fn_result;
	assign branch_taken = stage.ctrl.is_branch && (stage.ra_data == stage.rt_data);

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module reg_file (
	input  logic                clock,
	input  logic                rst_n,
	input  core_pkg::reg_addr_t ra_addr,
	input  core_pkg::reg_addr_t rt_addr,
	output core_pkg::word_t     ra_data,
	output core_pkg::word_t     rt_data,
	input  logic                we,
	input  core_pkg::reg_addr_t wa,
	input  core_pkg::word_t     wd
);
	import core_pkg::*;

	word_t regs [`CORE_NREGS];
	logic  write_ok;

	assign write_ok = we && (wa != '0);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < `CORE_NREGS; i++)
				regs[i] <= '0;
		end else if (write_ok) begin
			regs[wa] <= wd;
		end
	end

	// the writeback value is visible to decode in the same cycle
	assign ra_data = (write_ok && wa == ra_addr) ? wd : regs[ra_addr];
	assign rt_data = (write_ok && wa == rt_addr) ? wd : regs[rt_addr];

endmodule

`default_nettype wire

// ==== verilog/instr_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module instr_decoder (
	input  core_pkg::instr_t    instr,
	output core_pkg::ctrl_t     ctrl,
	output core_pkg::reg_addr_t ra_addr,
	output core_pkg::reg_addr_t rt_addr,
	output logic                uses_ra,
	output logic                uses_rt,
	output core_pkg::imm_t      imm,
	output core_pkg::word_t     imm_extend
);
	import core_pkg::*;

	opcode_e   opcode;
	reg_addr_t dest;

	assign opcode = opcode_e'(instr[31:26]);
	assign dest = instr[25:21];
	assign ra_addr = instr[20:16];
	assign imm = instr[13:0];
	assign imm_extend = {{(`CORE_XLEN - `CORE_IMM_W){imm[`CORE_IMM_W-1]}}, imm};

	always_comb begin
		ctrl = '0;
		uses_ra = 1'b0;
		uses_rt = 1'b0;
		rt_addr = instr[15:11];
		case (opcode)
			OP_ALU: begin
				ctrl.do_reg_write = 1'b1;
				ctrl.alu_fn = alu_fn_e'(instr[4:0]);
				uses_ra = 1'b1;
				uses_rt = 1'b1;
			end
			OP_ADDI: begin
				ctrl.do_reg_write = 1'b1;
				ctrl.alu_use_imm = 1'b1;
				uses_ra = 1'b1;
			end
			OP_LW: begin
				ctrl.do_dm_read = 1'b1;
				ctrl.do_reg_write = 1'b1;
				ctrl.wb_sel = WB_MEM;
				ctrl.alu_use_imm = 1'b1;
				uses_ra = 1'b1;
			end
			OP_SW: begin
				ctrl.do_dm_write = 1'b1;
				ctrl.alu_use_imm = 1'b1;
				rt_addr = dest; // store data comes from the destination field
				uses_ra = 1'b1;
				uses_rt = 1'b1;
			end
			OP_BEQ: begin
				ctrl.is_branch = 1'b1;
				rt_addr = dest;
				uses_ra = 1'b1;
				uses_rt = 1'b1;
			end
			default: begin
				ctrl = '0; // nop and unknown opcodes do nothing
			end
		endcase
		if (dest == '0)
			ctrl.do_reg_write = 1'b0; // a write to r0 never leaves the decoder
		ctrl.write_reg_addr = ctrl.do_reg_write ? dest : '0;
	end

endmodule

`default_nettype wire

// ==== verilog/core_pkg.sv ====
`default_nettype none

`include "core_params.svh"

package core_pkg;

	typedef logic [`CORE_XLEN-1:0] word_t;
	typedef logic [$clog2(`CORE_NREGS)-1:0] reg_addr_t;
	typedef logic [`CORE_IMM_W-1:0] imm_t;
	typedef logic [`CORE_PC_W-1:0] pc_t;
	typedef logic [31:0] instr_t;

	typedef enum logic [5:0] {
		OP_NOP = 6'd0,
		OP_ALU,
		OP_ADDI,
		OP_LW,
		OP_SW,
		OP_BEQ
	} opcode_e;

	typedef enum logic [4:0] {
		FN_ADD = 5'd0,
		FN_SUB,
		FN_AND,
		FN_OR,
		FN_XOR,
		FN_SLT
	} alu_fn_e;

	typedef enum logic [1:0] {
		WB_ALU = 2'd0,
		WB_MEM
	} wb_sel_e;

	typedef struct packed {
		logic      do_dm_read;
		logic      do_dm_write;
		logic      do_reg_write;
		reg_addr_t write_reg_addr;
		wb_sel_e   wb_sel;
		alu_fn_e   alu_fn;
		logic      alu_use_imm;
		logic      is_branch;
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t ra_data;
		word_t rt_data;
		word_t imm_extend;
		imm_t  imm;
	} id_ex_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t alu_result; // branch target for a BEQ
		word_t rt_data;
		logic  branch_taken;
	} ex_mem_t;

	typedef struct packed {
		logic      do_reg_write;
		reg_addr_t write_reg_addr;
		word_t     write_reg_data;
	} mem_wb_t;

endpackage

`default_nettype wire

// ==== verilog/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data path width, also the width of an instruction word
`define CORE_XLEN 32

`define CORE_NREGS 32

// immediate field as encoded in bits 13..0
`define CORE_IMM_W 14

`define CORE_DMEM_WORDS 64

// instruction memory is word addressed, so this counts instructions
`define CORE_PC_W 8

`endif
